// File: bench/tb_tlu_controller.sv
/* testbench for the TLU controller, bus and trigger stimulus, reference trigger
   words and counters, FIFO and register comparison with per-test reporting */
`timescale 1ns/1ps

module tb_tlu_controller;
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;   // about four times the full run

    logic BUS_CLK;
    logic RST;
    logic [BUS_ADDR_W-1:0] bus_add;
    logic [7:0] bus_data_in;
    logic bus_rd;
    logic bus_wr;
    logic [7:0] bus_data_out;
    logic fifo_read;
    logic fifo_empty;
    trigger_word_u fifo_data;
    logic [7:0] trigger;
    logic [7:0] trigger_veto;
    logic ext_trigger_enable;
    logic trigger_acknowledge;
    logic trigger_accepted_flag;
    logic tlu_trigger;
    logic tlu_busy;

    int seed = 68;
    int cycles;
    int errors = 0;
    int checks = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int pops = 0;
    int err_start;

    // reference model and shadow of the configuration
    logic [31:0] ref_count;
    logic [7:0] ref_lost;
    logic [31:0] exp_q [$];
    logic [31:0] exp_w;
    logic [TS_W-1:0] last_ts;
    bit ts_mode;
    bit tb_en;
    logic [7:0] tb_sel;
    logic [7:0] tb_inv;
    logic [7:0] tb_vsel;
    logic [31:0] tb_max;
    logic [7:0] trig_rest;   // idle level of the trigger inputs

    tlu_controller tlu_controller_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .bus_add(bus_add),
        .bus_data_in(bus_data_in),
        .bus_rd(bus_rd),
        .bus_wr(bus_wr),
        .bus_data_out(bus_data_out),
        .fifo_read(fifo_read),
        .fifo_empty(fifo_empty),
        .fifo_data(fifo_data),
        .trigger(trigger),
        .trigger_veto(trigger_veto),
        .ext_trigger_enable(ext_trigger_enable),
        .trigger_acknowledge(trigger_acknowledge),
        .trigger_accepted_flag(trigger_accepted_flag),
        .tlu_trigger(tlu_trigger),
        .tlu_busy(tlu_busy)
    );

    initial
    begin
        BUS_CLK = 1'b0;
        forever #4 BUS_CLK = ~BUS_CLK;
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge BUS_CLK);
            cycles++;
        end
        $display("timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // trigger word as the marker and count rules give it, timestamp left at zero
    function automatic logic [31:0] expected_word(input logic [31:0] count, input bit use_ts);
        if (use_ts)
            return {1'b1, 15'd0, count[15:0]};
        return {1'b1, count[30:0]};
    endfunction

    function automatic logic [7:0] default_value(input int addr);
        if (addr == 0)
            return VERSION;
        if (addr == 3)
            return 8'hff;
        return 8'h00;
    endfunction

    // level of the combined trigger for one input pattern, bit by bit
    function automatic bit selected_or(input logic [7:0] drive);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            if (tb_sel[i] && (drive[i] != tb_inv[i]))
                hit = 1'b1;   // selected input away from its inverted level
        end
        return hit;
    endfunction

    function automatic bit expect_accept(input logic [7:0] drive, input logic [7:0] vdrive);
        bit edge_seen;
        edge_seen = (selected_or(drive) != selected_or(trig_rest));   // one rising edge either way
        return tb_en && edge_seen && !(|(vdrive & tb_vsel))
               && (tb_max == 0 || ref_count < tb_max);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_start)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_data_in <= data;
        bus_wr <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK);
        data = bus_data_out;
    endtask

    task automatic read_check(input logic [BUS_ADDR_W-1:0] addr, input logic [7:0] exp);
        logic [7:0] b;
        bus_read(addr, b);
        check($sformatf("bus_data_out[addr %0d]", addr), exp, b);
    endtask

    // byte 0 first, upper bytes then come from the latched copy
    task automatic count_check();
        logic [7:0] b;
        logic [31:0] value;
        for (int i = 0; i < 4; i++)
        begin
            bus_read(ADDR_TRIG_COUNT + i, b);
            value[8*i +: 8] = b;
        end
        check("trigger_count", ref_count, value);
    endtask

    task automatic soft_reset();
        logic [7:0] b;
        bus_write(ADDR_SOFT_RST_VERSION, 8'h00);
        @(posedge BUS_CLK);
        trigger <= 8'h00;
        ref_count = 0;
        ref_lost = 0;
        exp_q.delete();
        last_ts = 0;
        ts_mode = 0;
        pops = 0;
        tb_en = 0;
        tb_sel = 8'h00;
        tb_inv = 8'h00;
        tb_vsel = 8'hff;
        tb_max = 0;
        trig_rest = 8'h00;
        count_check();
        bus_read(ADDR_LOST_COUNT, b);
        check("lost_count", 8'h00, b);
    endtask

    // select off while the idle level moves, so no edge appears
    task automatic set_trigger_select(input logic [7:0] sel, input logic [7:0] inv);
        bus_write(ADDR_TRIG_SELECT, 8'h00);
        bus_write(ADDR_TRIG_INVERT, inv);
        @(posedge BUS_CLK);
        trigger <= inv;
        bus_write(ADDR_TRIG_SELECT, sel);
        tb_sel = sel;
        tb_inv = inv;
        trig_rest = inv;
    endtask

    task automatic record_accept();
        ref_count = ref_count + 1;
        if (exp_q.size() < FIFO_DEPTH)
            exp_q.push_back(expected_word(ref_count, ts_mode));
        else if (ref_lost != 8'hff)
            ref_lost = ref_lost + 1;   // no credit, word dropped
    endtask

    task automatic acknowledge();
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b1;
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b0;
    endtask

    task automatic send_pulse(input logic [7:0] drive, input logic [7:0] vdrive);
        bit exp_acc;
        bit seen;
        exp_acc = expect_accept(drive, vdrive);
        seen = 1'b0;
        @(posedge BUS_CLK);
        trigger <= drive;
        trigger_veto <= vdrive;
        for (int n = 0; n < 12; n++)
        begin
            @(posedge BUS_CLK);
            if (n == 5)
                trigger <= trig_rest;
            @(negedge BUS_CLK);
            if (trigger_accepted_flag)
                seen = 1'b1;
        end
        @(posedge BUS_CLK);
        trigger_veto <= 8'h00;
        check("trigger_accepted_flag", exp_acc, seen);
        if (exp_acc)
            record_accept();
        if (seen)
            acknowledge();
    endtask

    task automatic tlu_pulse(input bit drop_first, input int hold);
        int n;
        bit seen;
        @(posedge BUS_CLK);
        tlu_trigger <= 1'b1;
        seen = 1'b0;
        n = 0;
        while (!seen && n < 20)
        begin
            @(negedge BUS_CLK);
            seen = trigger_accepted_flag;
            n++;
        end
        assert (seen)
        else
        begin
            errors++;
            $display("%0t tlu_trigger was not accepted within 20 cycles", $time);
        end
        if (seen)
            record_accept();
        check("tlu_busy", 1'b1, tlu_busy);   // rises with the flag
        if (drop_first)
        begin
            @(posedge BUS_CLK);
            tlu_trigger <= 1'b0;
        end
        else
            acknowledge();
        repeat (hold)
        begin
            @(negedge BUS_CLK);
            check("tlu_busy", 1'b1, tlu_busy);
        end
        if (drop_first)
            acknowledge();
        else
        begin
            @(posedge BUS_CLK);
            tlu_trigger <= 1'b0;
        end
        n = 0;
        @(negedge BUS_CLK);
        while (tlu_busy && n < 20)
        begin
            @(negedge BUS_CLK);
            n++;
        end
        assert (!tlu_busy)
        else
        begin
            errors++;
            $display("%0t tlu_busy stayed high after acknowledge and tlu_trigger low", $time);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        @(negedge BUS_CLK);
        while (!fifo_empty && n < 4 * FIFO_DEPTH)
        begin
            @(posedge BUS_CLK);
            fifo_read <= 1'b1;
            @(posedge BUS_CLK);
            fifo_read <= 1'b0;
            @(negedge BUS_CLK);
            n++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            errors++;
            $display("%0t %0d expected trigger words never came out of the FIFO",
                     $time, exp_q.size());
        end
    endtask

    // compares each popped word with the reference queue
    always @(negedge BUS_CLK)
    begin
        if (!RST && fifo_read && !fifo_empty)
        begin
            pops++;
            assert (exp_q.size() > 0)
            else
            begin
                errors++;
                $display("%0t FIFO returned a word that the reference does not hold", $time);
            end
            if (exp_q.size() > 0)
            begin
                exp_w = exp_q.pop_front();
                if (ts_mode)
                begin
                    check("fifo_data.ts_view.count", exp_w[15:0], fifo_data.ts_view.count);
                    check("fifo_data.ts_view.marker", exp_w[31], fifo_data.ts_view.marker);
                    assert (fifo_data.ts_view.timestamp > last_ts)
                    else
                    begin
                        errors++;
                        $display("%0t timestamp %0d did not increase past %0d", $time,
                                 fifo_data.ts_view.timestamp, last_ts);
                    end
                    last_ts = fifo_data.ts_view.timestamp;
                end
                else
                    check("fifo_data", exp_w, fifo_data);
            end
        end
    end

    initial
    begin
        logic [7:0] b;
        logic [7:0] d;
        int regs [7];
        int assert_fails;
        regs = '{2, 3, 4, 8, 9, 10, 11};
        RST = 1'b1;
        bus_add = '0;
        bus_data_in = 8'h00;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        fifo_read = 1'b0;
        trigger = 8'h00;
        trigger_veto = 8'h00;
        ext_trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        tlu_trigger = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        RST <= 1'b0;

        err_start = errors;
        for (int a = 0; a < 21; a++)
            read_check(16'(a), default_value(a));
        read_check(16'h8000, 8'h00);
        d = 8'($random(seed));
        bus_write(ADDR_CONF, d);
        read_check(ADDR_CONF, d & 8'h8b);   // mode, enable and write_ts bits only
        foreach (regs[i])
        begin
            d = 8'($random(seed));
            bus_write(16'(regs[i]), d);
            read_check(16'(regs[i]), d);
        end
        soft_reset();
        for (int a = 0; a < 21; a++)
            read_check(16'(a), default_value(a));
        end_test("registers");

        err_start = errors;
        soft_reset();
        bus_write(ADDR_CONF, 8'h08);
        tb_en = 1;
        for (int g = 0; g < 20; g++)
        begin
            set_trigger_select(8'($random(seed)), 8'($random(seed)));
            for (int p = 0; p < 6; p++)
                send_pulse(trig_rest ^ 8'($random(seed)), 8'h00);
            drain();
        end
        count_check();
        end_test("standard mode");

        err_start = errors;
        soft_reset();
        bus_write(ADDR_CONF, 8'h08);
        tb_en = 1;
        set_trigger_select(8'hff, 8'h00);
        bus_write(ADDR_VETO_SELECT, 8'h0f);
        tb_vsel = 8'h0f;
        for (int p = 0; p < 16; p++)
        begin
            d = 8'($random(seed));
            if (p % 2 == 0)
                d = d & 8'hf0;   // unselected veto inputs only
            send_pulse(8'($random(seed)) | 8'h01, d);
            if (p % 4 == 3)
                drain();
        end
        count_check();
        end_test("veto");

        err_start = errors;
        soft_reset();
        bus_write(ADDR_CONF, 8'h08);
        tb_en = 1;
        set_trigger_select(8'hff, 8'h00);
        bus_write(ADDR_COUNT_MAX, 8'd5);
        tb_max = 5;
        repeat (10) send_pulse(8'h01, 8'h00);
        drain();
        check("popped words", 5, pops);
        count_check();
        end_test("count limit");

        err_start = errors;
        soft_reset();
        bus_write(ADDR_CONF, 8'h08);
        tb_en = 1;
        set_trigger_select(8'hff, 8'h00);
        repeat (11) send_pulse(8'h01, 8'h00);
        bus_read(ADDR_LOST_COUNT, b);
        check("lost_count", ref_lost, b);
        drain();
        check("popped words", FIFO_DEPTH, pops);
        count_check();
        end_test("back-pressure");

        err_start = errors;
        soft_reset();
        bus_write(ADDR_CONF, 8'h82);   // handshake, timestamp words
        ts_mode = 1;
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b1;
        for (int p = 0; p < 6; p++)
            tlu_pulse(p[0], 3 + ($random(seed) & 3));
        drain();
        count_check();
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b0;
        end_test("handshake mode");

        assert_fails = tlu_controller_inst.tlu_trigger_fsm_inst.fsm_assert_inst.fail_count;
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_ok, tests_bad, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: bench/tlu_controller_assert.sv
/* concurrent checks on the trigger FSM, accepted flag, credit count and TLU busy,
   bound into every tlu_trigger_fsm instance */
`timescale 1ns/1ps

module tlu_controller_assert (
    input logic BUS_CLK,
    input logic RST,
    input logic soft_rst,
    input logic [1:0] mode,
    input logic trigger_accepted_flag,
    input logic wr_en,
    input logic [tlu_data_pkg::CREDIT_W-1:0] credits,
    input logic tlu_busy
);
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;

    int fail_count = 0;   // read by the testbench at the end of the run

    flag_one_cycle: assert property (@(posedge BUS_CLK) disable iff (RST || soft_rst)
        trigger_accepted_flag |=> !trigger_accepted_flag)
    else
    begin
        fail_count++;
        $error("trigger_accepted_flag high for more than one cycle");
    end

    // a write always needs a credit left
    write_has_credit: assert property (@(posedge BUS_CLK) disable iff (RST || soft_rst)
        wr_en |-> (credits != '0))
    else
    begin
        fail_count++;
        $error("FIFO write issued with no credit left");
    end

    credit_bound: assert property (@(posedge BUS_CLK) disable iff (RST || soft_rst)
        credits <= CREDIT_W'(FIFO_DEPTH))
    else
    begin
        fail_count++;
        $error("credit count above the FIFO depth");
    end

    busy_only_handshake: assert property (@(posedge BUS_CLK) disable iff (RST || soft_rst)
        (mode < MODE_TLU_HANDSHAKE) |-> !tlu_busy)
    else
    begin
        fail_count++;
        $error("tlu_busy high outside the handshake mode");
    end

endmodule

bind tlu_trigger_fsm tlu_controller_assert fsm_assert_inst (
    .BUS_CLK(BUS_CLK),
    .RST(RST),
    .soft_rst(soft_rst),
    .mode(cfg.mode),
    .trigger_accepted_flag(trigger_accepted_flag),
    .wr_en(wr_en),
    .credits(credits),
    .tlu_busy(tlu_busy)
);

// File: rtl/tlu_cfg_pkg.sv
/* register map, trigger modes and the configuration and status structs
   shared by the register bank, input block and trigger FSM */
package tlu_cfg_pkg;

    localparam int BUS_ADDR_W = 16;
    localparam logic [7:0] VERSION = 8'd6;

    // byte addresses on the register bus
    localparam logic [BUS_ADDR_W-1:0] ADDR_SOFT_RST_VERSION = 16'd0;
    localparam logic [BUS_ADDR_W-1:0] ADDR_CONF = 16'd1;
    localparam logic [BUS_ADDR_W-1:0] ADDR_TRIG_SELECT = 16'd2;
    localparam logic [BUS_ADDR_W-1:0] ADDR_VETO_SELECT = 16'd3;
    localparam logic [BUS_ADDR_W-1:0] ADDR_TRIG_INVERT = 16'd4;
    localparam logic [BUS_ADDR_W-1:0] ADDR_COUNT_MAX = 16'd8;   // 4 bytes, lsb first
    localparam logic [BUS_ADDR_W-1:0] ADDR_TRIG_COUNT = 16'd12; // 4 bytes, lsb first
    localparam logic [BUS_ADDR_W-1:0] ADDR_LOST_COUNT = 16'd16;
    localparam int REG_COUNT = 17;

    // mode 3 is reserved and handled like the simple handshake
    typedef enum logic [1:0] {
        MODE_STANDARD = 2'd0,
        MODE_TLU_NO_HANDSHAKE = 2'd1,
        MODE_TLU_HANDSHAKE = 2'd2
    } tlu_mode_e;

    typedef struct packed {
        logic [1:0] mode;           // conf bits 1:0
        logic trigger_enable;       // conf bit 3
        logic write_ts;             // conf bit 7
        logic [7:0] trig_select;
        logic [7:0] veto_select;
        logic [7:0] trig_invert;
        logic [31:0] count_max;     // 0 = no limit
    } tlu_cfg_t;

    typedef struct packed {
        logic [31:0] trigger_count;
        logic [7:0] lost_count;
    } tlu_status_t;

endpackage

// File: rtl/tlu_controller.sv
/* TLU controller top, register bank, input block, trigger FSM and FIFO */
`timescale 1ns/1ps

module tlu_controller (
    input logic BUS_CLK,
    input logic RST,
    input logic [tlu_cfg_pkg::BUS_ADDR_W-1:0] bus_add,
    input logic [7:0] bus_data_in,
    input logic bus_rd,
    input logic bus_wr,
    output logic [7:0] bus_data_out,
    input logic fifo_read,
    output logic fifo_empty,
    output tlu_data_pkg::trigger_word_u fifo_data,
    input logic [7:0] trigger,
    input logic [7:0] trigger_veto,
    input logic ext_trigger_enable,
    input logic trigger_acknowledge,
    output logic trigger_accepted_flag,
    input logic tlu_trigger,
    output logic tlu_busy
);
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;

    tlu_cfg_t cfg;
    tlu_status_t status;
    logic soft_rst;
    logic trig_rise;
    logic trig_level;
    logic veto;
    logic wr_en;
    trigger_word_u wr_word;
    logic credit_return;

    tlu_reg_bank tlu_reg_bank_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .bus_add(bus_add),
        .bus_data_in(bus_data_in),
        .bus_rd(bus_rd),
        .bus_wr(bus_wr),
        .bus_data_out(bus_data_out),
        .status(status),
        .cfg(cfg),
        .soft_rst(soft_rst)
    );

    tlu_trigger_input tlu_trigger_input_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .trigger(trigger),
        .trigger_veto(trigger_veto),
        .tlu_trigger(tlu_trigger),
        .cfg(cfg),
        .trig_rise(trig_rise),
        .trig_level(trig_level),
        .veto(veto)
    );

    tlu_trigger_fsm tlu_trigger_fsm_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .soft_rst(soft_rst),
        .cfg(cfg),
        .trig_rise(trig_rise),
        .trig_level(trig_level),
        .veto(veto),
        .ext_trigger_enable(ext_trigger_enable),
        .trigger_acknowledge(trigger_acknowledge),
        .credit_return(credit_return),
        .wr_en(wr_en),
        .wr_word(wr_word),
        .status(status),
        .trigger_accepted_flag(trigger_accepted_flag),
        .tlu_busy(tlu_busy)
    );

    tlu_trigger_fifo tlu_trigger_fifo_inst (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .soft_rst(soft_rst),
        .wr_en(wr_en),
        .wr_word(wr_word),
        .fifo_read(fifo_read),
        .fifo_data(fifo_data),
        .fifo_empty(fifo_empty),
        .credit_return(credit_return)
    );

endmodule

// File: rtl/tlu_data_pkg.sv
/* FIFO depth, credit width and the trigger word with its two views */
package tlu_data_pkg;

    localparam int FIFO_DEPTH = 8;
    localparam int CREDIT_W = 4;    // holds 0 to FIFO_DEPTH
    localparam int TS_W = 15;

    // plain trigger number
    typedef struct packed {
        logic marker;
        logic [30:0] count;
    } count_view_t;

    // timestamp with the low bits of the trigger number
    typedef struct packed {
        logic marker;
        logic [TS_W-1:0] timestamp;
        logic [30-TS_W:0] count;
    } ts_view_t;

    // marker bit is always set, count is the value after the increment
    typedef union packed {
        count_view_t count_view;
        ts_view_t ts_view;
    } trigger_word_u;

endpackage

// File: rtl/tlu_reg_bank.sv
/* byte-wide register file with soft reset decode and registered read mux,
   upper trigger count bytes come from a buffer latched on the byte 0 read */
`timescale 1ns/1ps

module tlu_reg_bank (
    input logic BUS_CLK,
    input logic RST,
    input logic [tlu_cfg_pkg::BUS_ADDR_W-1:0] bus_add,
    input logic [7:0] bus_data_in,
    input logic bus_rd,
    input logic bus_wr,
    output logic [7:0] bus_data_out,
    input tlu_cfg_pkg::tlu_status_t status,
    output tlu_cfg_pkg::tlu_cfg_t cfg,
    output logic soft_rst
);
    import tlu_cfg_pkg::*;

    logic [31:0] count_buf;   // trigger count snapshot for bytes 1 to 3
    logic [7:0] rd_byte;

    assign soft_rst = bus_wr && (bus_add == ADDR_SOFT_RST_VERSION);

    // configuration registers
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            cfg <= '0;
            cfg.veto_select <= 8'hff;   // all vetoes active by default
        end
        else if (bus_wr && bus_add < REG_COUNT)
        begin
            case (bus_add)
                ADDR_CONF:
                begin
                    cfg.mode <= bus_data_in[1:0];
                    cfg.trigger_enable <= bus_data_in[3];
                    cfg.write_ts <= bus_data_in[7];
                end
                ADDR_TRIG_SELECT: cfg.trig_select <= bus_data_in;
                ADDR_VETO_SELECT: cfg.veto_select <= bus_data_in;
                ADDR_TRIG_INVERT: cfg.trig_invert <= bus_data_in;
                ADDR_COUNT_MAX: cfg.count_max[7:0] <= bus_data_in;
                ADDR_COUNT_MAX + 1: cfg.count_max[15:8] <= bus_data_in;
                ADDR_COUNT_MAX + 2: cfg.count_max[23:16] <= bus_data_in;
                ADDR_COUNT_MAX + 3: cfg.count_max[31:24] <= bus_data_in;
                default: ; // read-only or unmapped
            endcase
        end
    end

    // snapshot so a 4-byte read sees one consistent value
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
            count_buf <= '0;
        else if (bus_rd && bus_add == ADDR_TRIG_COUNT)
            count_buf <= status.trigger_count;
    end

    always_comb
    begin
        rd_byte = 8'h00;
        case (bus_add)
            ADDR_SOFT_RST_VERSION: rd_byte = VERSION;
            ADDR_CONF: rd_byte = {cfg.write_ts, 3'b000, cfg.trigger_enable, 1'b0, cfg.mode};
            ADDR_TRIG_SELECT: rd_byte = cfg.trig_select;
            ADDR_VETO_SELECT: rd_byte = cfg.veto_select;
            ADDR_TRIG_INVERT: rd_byte = cfg.trig_invert;
            ADDR_COUNT_MAX: rd_byte = cfg.count_max[7:0];
            ADDR_COUNT_MAX + 1: rd_byte = cfg.count_max[15:8];
            ADDR_COUNT_MAX + 2: rd_byte = cfg.count_max[23:16];
            ADDR_COUNT_MAX + 3: rd_byte = cfg.count_max[31:24];
            ADDR_TRIG_COUNT: rd_byte = status.trigger_count[7:0];  // live, same value as latched
            ADDR_TRIG_COUNT + 1: rd_byte = count_buf[15:8];
            ADDR_TRIG_COUNT + 2: rd_byte = count_buf[23:16];
            ADDR_TRIG_COUNT + 3: rd_byte = count_buf[31:24];
            ADDR_LOST_COUNT: rd_byte = status.lost_count;
            default: rd_byte = 8'h00;
        endcase
    end

    // read data valid one cycle after bus_rd
    always_ff @(posedge BUS_CLK)
    begin
        if (bus_rd)
            bus_data_out <= rd_byte;
    end

endmodule

// File: rtl/tlu_trigger_fifo.sv
/* trigger word FIFO, circular buffer with one credit returned per pop */
`timescale 1ns/1ps

module tlu_trigger_fifo (
    input logic BUS_CLK,
    input logic RST,
    input logic soft_rst,
    input logic wr_en,
    input tlu_data_pkg::trigger_word_u wr_word,
    input logic fifo_read,
    output tlu_data_pkg::trigger_word_u fifo_data,
    output logic fifo_empty,
    output logic credit_return
);
    import tlu_data_pkg::*;

    trigger_word_u mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0] count;
    logic pop;

    assign fifo_empty = (count == '0);
    assign pop = fifo_read && !fifo_empty;   // read while empty ignored
    assign fifo_data = mem[rd_ptr];          // head word

    // no full check, the FSM credits keep writes below depth
    always_ff @(posedge BUS_CLK)
    begin
        if (wr_en)
            mem[wr_ptr] <= wr_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop;
        end
    end

endmodule

// File: rtl/tlu_trigger_fsm.sv
/* trigger acceptance FSM with TLU handshake, trigger and lost counters,
   timestamp, trigger word build and FIFO credit count */
`timescale 1ns/1ps

module tlu_trigger_fsm (
    input logic BUS_CLK,
    input logic RST,
    input logic soft_rst,
    input tlu_cfg_pkg::tlu_cfg_t cfg,
    input logic trig_rise,
    input logic trig_level,
    input logic veto,
    input logic ext_trigger_enable,
    input logic trigger_acknowledge,
    input logic credit_return,
    output logic wr_en,
    output tlu_data_pkg::trigger_word_u wr_word,
    output tlu_cfg_pkg::tlu_status_t status,
    output logic trigger_accepted_flag,
    output logic tlu_busy
);
    import tlu_cfg_pkg::*;
    import tlu_data_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_TLU_LOW
    } state_e;

    state_e state;
    logic [31:0] trig_count;
    logic [31:0] count_next;
    logic [7:0] lost_count;
    logic [TS_W-1:0] timestamp;
    logic [CREDIT_W-1:0] credits;
    logic handshake;
    logic limit_ok;
    logic accept;
    trigger_word_u word_next;

    assign handshake = (cfg.mode >= MODE_TLU_HANDSHAKE);  // reserved mode 3 included
    assign limit_ok = (cfg.count_max == 32'd0) || (trig_count < cfg.count_max);
    assign accept = (state == IDLE) && trig_rise && !veto && limit_ok
                    && (cfg.trigger_enable || ext_trigger_enable);
    assign count_next = trig_count + 32'd1;

    always_comb
    begin
        word_next = '0;
        if (cfg.write_ts)
        begin
            word_next.ts_view.marker = 1'b1;
            word_next.ts_view.timestamp = timestamp;
            word_next.ts_view.count = count_next[30-TS_W:0];
        end
        else
        begin
            word_next.count_view.marker = 1'b1;
            word_next.count_view.count = count_next[30:0];
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
        begin
            state <= IDLE;
            trig_count <= '0;
            lost_count <= '0;
            trigger_accepted_flag <= 1'b0;
            tlu_busy <= 1'b0;
            wr_en <= 1'b0;
        end
        else
        begin
            trigger_accepted_flag <= accept;
            wr_en <= accept && (credits != '0);
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        state <= WAIT_ACK;
                        trig_count <= count_next;
                        tlu_busy <= handshake;
                        if (credits == '0 && lost_count != 8'hff)
                            lost_count <= lost_count + 8'd1;   // word dropped
                    end
                end
                WAIT_ACK:
                begin
                    if (trigger_acknowledge)
                        state <= handshake ? WAIT_TLU_LOW : IDLE;
                end
                WAIT_TLU_LOW:
                begin
                    if (!trig_level)
                    begin
                        state <= IDLE;
                        tlu_busy <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // spent when wr_en is seen, so a pending write is counted before the next accept
    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
            credits <= CREDIT_W'(FIFO_DEPTH);
        else
        begin
            case ({wr_en, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;   // none, or both in one cycle
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST || soft_rst)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;   // free running
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (accept)
            wr_word <= word_next;
    end

    assign status = '{trigger_count: trig_count, lost_count: lost_count};

endmodule

// File: rtl/tlu_trigger_input.sv
/* trigger invert, select and OR, veto mask, two-flop capture and edge detect */
`timescale 1ns/1ps

module tlu_trigger_input (
    input logic BUS_CLK,
    input logic RST,
    input logic [7:0] trigger,
    input logic [7:0] trigger_veto,
    input logic tlu_trigger,
    input tlu_cfg_pkg::tlu_cfg_t cfg,
    output logic trig_rise,
    output logic trig_level,
    output logic veto
);
    import tlu_cfg_pkg::*;

    logic trig_or;
    logic veto_or;
    logic source;
    logic [1:0] source_sync;   // [1] is the captured level
    logic [1:0] veto_sync;
    logic source_prev;

    assign trig_or = |((trigger ^ cfg.trig_invert) & cfg.trig_select);
    assign veto_or = |(trigger_veto & cfg.veto_select);

    // both TLU modes take the RJ45 trigger line
    assign source = (cfg.mode == MODE_STANDARD) ? trig_or : tlu_trigger;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            source_sync <= 2'b00;
            veto_sync <= 2'b00;
            source_prev <= 1'b0;
        end
        else
        begin
            source_sync <= {source_sync[0], source};
            veto_sync <= {veto_sync[0], veto_or};
            source_prev <= source_sync[1];
        end
    end

    assign trig_level = source_sync[1];
    assign veto = veto_sync[1];
    assign trig_rise = source_sync[1] & ~source_prev;   // one cycle per rising edge

endmodule

// File: tlu_controller.f
rtl/tlu_cfg_pkg.sv
rtl/tlu_data_pkg.sv
rtl/tlu_reg_bank.sv
rtl/tlu_trigger_input.sv
rtl/tlu_trigger_fsm.sv
rtl/tlu_trigger_fifo.sv
rtl/tlu_controller.sv
bench/tlu_controller_assert.sv
bench/tb_tlu_controller.sv
